/* Makefile */
TOP       ?= tb_axil_reg_top
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LOG       ?= sim.log

SRCS := $(filter-out +%,$(shell cat files.f))
HDRS := $(wildcard hw/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '>>> PASS' $(LOG)

$(BIN): $(SRCS) $(HDRS) files.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
+incdir+hw
hw/axil_pkg.sv
hw/axil_write_channel.sv
hw/axil_read_channel.sv
hw/axil_reg_bank.sv
hw/axil_reg_top.sv
tb/tb_axil_reg_top.sv

/* hw/axil_consts.svh */
`ifndef AXIL_CONSTS_SVH
`define AXIL_CONSTS_SVH

// Bus widths
`define AXIL_ADDR_W 64
`define AXIL_DATA_W 64
`define AXIL_STRB_W 8

// Register window
`define AXIL_REG_CNT 4

// Byte offset inside one 64-bit register
`define AXIL_ADDR_LSB 3

// Index bits right above the byte offset
`define AXIL_IDX_W 2

// AXI response codes
`define AXIL_RESP_OKAY 2'b00
`define AXIL_RESP_SLVERR 2'b10

`endif

/* hw/axil_pkg.sv */
`include "axil_consts.svh"

package axil_pkg;

	// Plain vectors for the widths on the bus
	typedef logic [`AXIL_ADDR_W-1:0] addr_t;
	typedef logic [`AXIL_DATA_W-1:0] data_t;
	typedef logic [`AXIL_STRB_W-1:0] strb_t;
	typedef logic [1:0] resp_t;

	// Register select field of the address
	typedef logic [`AXIL_IDX_W-1:0] reg_idx_t;

	// One captured write, address and data taken together
	typedef struct packed
	{
		addr_t addr;
		data_t data;
		strb_t strb;
	} wr_req_t;

	// Answer of the bank to a read address
	typedef struct packed
	{
		data_t data;
		resp_t resp;
	} rd_rsp_t;

	// Write channel FSM
	typedef enum logic [1:0]
	{
		W_IDLE,
		W_ACCEPT,
		W_RESP
	} wr_state_t;

endpackage

/* hw/axil_read_channel.sv */
`timescale 1ns/1ps

`include "axil_consts.svh"

module axil_read_channel
(
	input  logic               S_AXI_ACLK,
	input  logic               S_AXI_ARESETN,

	input  axil_pkg::addr_t    araddr,
	input  logic               arvalid,
	output logic               arready,

	output axil_pkg::data_t    rdata,
	output axil_pkg::resp_t    rresp,
	output logic               rvalid,
	input  logic               rready,

	output axil_pkg::addr_t    rd_addr,
	input  axil_pkg::rd_rsp_t  rd_rsp
);

	// Address taken, data not yet registered
	logic rd_pend;

	logic ar_hs;

	assign ar_hs = arready && arvalid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arready <= 1'b0;
			rd_pend <= 1'b0;
			rvalid  <= 1'b0;
		end
		else
		begin
			// One-cycle pulse, only with nothing in flight
			arready <= !arready && arvalid && !rd_pend && !rvalid;
			rd_pend <= ar_hs;

			if (rd_pend)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_hs)
			rd_addr <= araddr;
	end

	// Snapshot of the selected register
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_pend)
		begin
			rdata <= rd_rsp.data;
			rresp <= rd_rsp.resp;
		end
	end

	// No new AR while the data is still waiting
	a_no_ar_on_r: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(arready && rvalid));

	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* hw/axil_reg_bank.sv */
`timescale 1ns/1ps

`include "axil_consts.svh"

module axil_reg_bank
(
	input  logic               S_AXI_ACLK,
	input  logic               S_AXI_ARESETN,

	input  axil_pkg::wr_req_t  wr_req,
	input  logic               wr_en,
	output axil_pkg::resp_t    wr_resp,

	input  axil_pkg::addr_t    rd_addr,
	output axil_pkg::rd_rsp_t  rd_rsp
);

	localparam int HI_LSB = `AXIL_ADDR_LSB + `AXIL_IDX_W;

	axil_pkg::data_t [`AXIL_REG_CNT-1:0] regs;

	axil_pkg::reg_idx_t wr_idx;
	axil_pkg::reg_idx_t rd_idx;
	logic               wr_ok;
	logic               rd_ok;

	// Anything set above the index field is outside the window
	function automatic logic in_window(input axil_pkg::addr_t a);
		return (a[`AXIL_ADDR_W-1:HI_LSB] == '0);
	endfunction

	assign wr_idx = wr_req.addr[`AXIL_ADDR_LSB +: `AXIL_IDX_W];
	assign rd_idx = rd_addr[`AXIL_ADDR_LSB +: `AXIL_IDX_W];

	assign wr_ok = in_window(wr_req.addr);
	assign rd_ok = in_window(rd_addr);

	assign wr_resp = wr_ok ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;

	// Byte lanes follow the strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			regs <= '0;
		else if (wr_en && wr_ok)
		begin
			for (int b = 0; b < `AXIL_STRB_W; b++)
			begin
				if (wr_req.strb[b])
					regs[wr_idx][b*8 +: 8] <= wr_req.data[b*8 +: 8];
			end
		end
	end

	// Read mux
	always_comb
	begin
		if (rd_ok)
		begin
			rd_rsp.data = regs[rd_idx];
			rd_rsp.resp = `AXIL_RESP_OKAY;
		end
		else
		begin
			// zero data on a miss
			rd_rsp.data = '0;
			rd_rsp.resp = `AXIL_RESP_SLVERR;
		end
	end

	a_oor_write_noop: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_en && !wr_ok |=> $stable(regs));

endmodule

/* hw/axil_reg_top.sv */
`timescale 1ns/1ps

`include "axil_consts.svh"

module axil_reg_top
(
	input  logic             S_AXI_ACLK,
	input  logic             S_AXI_ARESETN,

	input  axil_pkg::addr_t  S_AXI_AWADDR,
	input  logic [2:0]       S_AXI_AWPROT,
	input  logic             S_AXI_AWVALID,
	output logic             S_AXI_AWREADY,

	input  axil_pkg::data_t  S_AXI_WDATA,
	input  axil_pkg::strb_t  S_AXI_WSTRB,
	input  logic             S_AXI_WVALID,
	output logic             S_AXI_WREADY,

	output axil_pkg::resp_t  S_AXI_BRESP,
	output logic             S_AXI_BVALID,
	input  logic             S_AXI_BREADY,

	input  axil_pkg::addr_t  S_AXI_ARADDR,
	input  logic [2:0]       S_AXI_ARPROT,
	input  logic             S_AXI_ARVALID,
	output logic             S_AXI_ARREADY,

	output axil_pkg::data_t  S_AXI_RDATA,
	output axil_pkg::resp_t  S_AXI_RRESP,
	output logic             S_AXI_RVALID,
	input  logic             S_AXI_RREADY
);

	// Write path into the bank
	axil_pkg::wr_req_t wr_req;
	logic              wr_en;
	axil_pkg::resp_t   wr_resp;

	// Read path
	axil_pkg::addr_t   rd_addr;
	axil_pkg::rd_rsp_t rd_rsp;

	axil_write_channel u_wr
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.awaddr        (S_AXI_AWADDR),
		.awvalid       (S_AXI_AWVALID),
		.awready       (S_AXI_AWREADY),
		.wdata         (S_AXI_WDATA),
		.wstrb         (S_AXI_WSTRB),
		.wvalid        (S_AXI_WVALID),
		.wready        (S_AXI_WREADY),
		.bresp         (S_AXI_BRESP),
		.bvalid        (S_AXI_BVALID),
		.bready        (S_AXI_BREADY),
		.wr_req        (wr_req),
		.wr_en         (wr_en),
		.wr_resp       (wr_resp)
	);

	axil_read_channel u_rd
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.araddr        (S_AXI_ARADDR),
		.arvalid       (S_AXI_ARVALID),
		.arready       (S_AXI_ARREADY),
		.rdata         (S_AXI_RDATA),
		.rresp         (S_AXI_RRESP),
		.rvalid        (S_AXI_RVALID),
		.rready        (S_AXI_RREADY),
		.rd_addr       (rd_addr),
		.rd_rsp        (rd_rsp)
	);

	axil_reg_bank u_bank
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_req        (wr_req),
		.wr_en         (wr_en),
		.wr_resp       (wr_resp),
		.rd_addr       (rd_addr),
		.rd_rsp        (rd_rsp)
	);

endmodule

/* hw/axil_write_channel.sv */
`timescale 1ns/1ps

`include "axil_consts.svh"

module axil_write_channel
(
	input  logic               S_AXI_ACLK,
	input  logic               S_AXI_ARESETN,

	input  axil_pkg::addr_t    awaddr,
	input  logic               awvalid,
	output logic               awready,

	input  axil_pkg::data_t    wdata,
	input  axil_pkg::strb_t    wstrb,
	input  logic               wvalid,
	output logic               wready,

	output axil_pkg::resp_t    bresp,
	output logic               bvalid,
	input  logic               bready,

	output axil_pkg::wr_req_t  wr_req,
	output logic               wr_en,
	input  axil_pkg::resp_t    wr_resp
);

	axil_pkg::wr_state_t state;

	logic both_valid;

	assign both_valid = awvalid && wvalid;

	// Address and data are accepted in the same single cycle
	assign awready = (state == axil_pkg::W_ACCEPT);
	assign wready  = (state == axil_pkg::W_ACCEPT);

	// Bank is written on the edge that closes the accept cycle
	assign wr_en = (state == axil_pkg::W_ACCEPT);

	assign bvalid = (state == axil_pkg::W_RESP);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			state <= axil_pkg::W_IDLE;
		else
		begin
			case (state)
				axil_pkg::W_IDLE:
				begin
					if (both_valid)
						state <= axil_pkg::W_ACCEPT;
				end
				axil_pkg::W_ACCEPT:
				begin
					state <= axil_pkg::W_RESP;
				end
				axil_pkg::W_RESP:
				begin
					// Next write waits for the B handshake
					if (bready)
						state <= axil_pkg::W_IDLE;
				end
				default:
				begin
					state <= axil_pkg::W_IDLE;
				end
			endcase
		end
	end

	// Request payload
	always_ff @(posedge S_AXI_ACLK)
	begin
		if ((state == axil_pkg::W_IDLE) && both_valid)
		begin
			wr_req.addr <= awaddr;
			wr_req.data <= wdata;
			wr_req.strb <= wstrb;
		end
	end

	// Response follows the decode of the captured address
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state == axil_pkg::W_ACCEPT)
			bresp <= wr_resp;
	end

	// Ready pair rises together and only while the master still offers both
	a_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(awready == wready) && (!awready || both_valid));

	// B stays put until taken
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

/* tb/tb_axil_reg_top.sv */
`timescale 1ns/1ps

`include "axil_consts.svh"

module tb_axil_reg_top;

	// One table row with the response the master should see
	typedef struct packed
	{
		logic              is_write;
		axil_pkg::addr_t   addr;
		axil_pkg::data_t   data;
		axil_pkg::strb_t   strb;
		axil_pkg::resp_t   resp;
	} op_t;

	localparam int RST_CYCLES = 8;
	localparam axil_pkg::resp_t RESP_OK = `AXIL_RESP_OKAY;
	localparam axil_pkg::resp_t RESP_ERR = `AXIL_RESP_SLVERR;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	axil_pkg::addr_t S_AXI_AWADDR;
	logic [2:0] S_AXI_AWPROT;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	axil_pkg::data_t S_AXI_WDATA;
	axil_pkg::strb_t S_AXI_WSTRB;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	axil_pkg::resp_t S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	axil_pkg::addr_t S_AXI_ARADDR;
	logic [2:0] S_AXI_ARPROT;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	axil_pkg::data_t S_AXI_RDATA;
	axil_pkg::resp_t S_AXI_RRESP;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;

	op_t ops[$];
	int table_len;
	integer seed;
	axil_pkg::data_t model[`AXIL_REG_CNT];

	// Previous-edge copies for the hold checks
	logic prev_bvalid;
	logic prev_bready;
	logic prev_rvalid;
	logic prev_rready;
	axil_pkg::data_t prev_rdata;

	axil_reg_top uut (.*);

	always #10 S_AXI_ACLK = ~S_AXI_ACLK;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input axil_pkg::data_t exp_val,
		input axil_pkg::data_t got_val);
		assert (got_val === exp_val)
		else
			report_failure($sformatf("MISMATCH at %0t ns: %s expected %h got %h",
				$time, name, exp_val, got_val));
	endtask

	task automatic check_rule(input logic ok, input string what);
		assert (ok)
		else
			report_failure($sformatf("Protocol error at %0t ns: %s", $time, what));
	endtask

	task automatic random_wait();
		int n;
		n = {$random(seed)} % 4;
		repeat (n) @(posedge S_AXI_ACLK);
	endtask

	// Anything set above the register index is outside the window
	function automatic logic in_window(input axil_pkg::addr_t a);
		return (a >> (`AXIL_ADDR_LSB + `AXIL_IDX_W)) == '0;
	endfunction

	function automatic axil_pkg::data_t merge_bytes(input axil_pkg::data_t old_val,
		input axil_pkg::data_t new_val, input axil_pkg::strb_t strb);
		axil_pkg::data_t mask;
		for (int i = 0; i < `AXIL_STRB_W; i++)
			mask[i*8 +: 8] = {8{strb[i]}};
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	function automatic void add_op(input logic w, input axil_pkg::addr_t a,
		input axil_pkg::data_t d, input axil_pkg::strb_t s, input axil_pkg::resp_t r);
		ops.push_back({w, a, d, s, r});
	endfunction

	// True when entry b exists and is the same kind of access as entry a
	function automatic logic same_kind(input int a, input int b);
		return (b >= 0) && (b < ops.size()) && (ops[a].is_write == ops[b].is_write);
	endfunction

	function automatic void build_table();
		// Reset values
		add_op(1'b0, 64'h00, '0, '0, RESP_OK);
		add_op(1'b0, 64'h08, '0, '0, RESP_OK);
		add_op(1'b0, 64'h10, '0, '0, RESP_OK);
		add_op(1'b0, 64'h18, '0, '0, RESP_OK);
		// Full-strobe writes and readback
		add_op(1'b1, 64'h00, 64'h0123_4567_89ab_cdef, 8'hff, RESP_OK);
		add_op(1'b1, 64'h08, 64'hfedc_ba98_7654_3210, 8'hff, RESP_OK);
		add_op(1'b1, 64'h10, 64'hdead_beef_cafe_f00d, 8'hff, RESP_OK);
		add_op(1'b1, 64'h18, 64'h0f1e_2d3c_4b5a_6978, 8'hff, RESP_OK);
		add_op(1'b0, 64'h00, '0, '0, RESP_OK);
		add_op(1'b0, 64'h08, '0, '0, RESP_OK);
		add_op(1'b0, 64'h10, '0, '0, RESP_OK);
		add_op(1'b0, 64'h18, '0, '0, RESP_OK);
		// Partial strobes, one with byte offset bits set
		add_op(1'b1, 64'h08, 64'h1111_2222_3333_4444, 8'h0f, RESP_OK);
		add_op(1'b1, 64'h13, 64'haaaa_bbbb_cccc_dddd, 8'ha5, RESP_OK);
		add_op(1'b1, 64'h00, 64'h5555_5555_5555_5555, 8'h80, RESP_OK);
		add_op(1'b1, 64'h18, 64'h9999_9999_9999_9999, 8'h01, RESP_OK);
		add_op(1'b0, 64'h08, '0, '0, RESP_OK);
		add_op(1'b0, 64'h0c, '0, '0, RESP_OK);
		add_op(1'b0, 64'h10, '0, '0, RESP_OK);
		add_op(1'b0, 64'h00, '0, '0, RESP_OK);
		add_op(1'b0, 64'h18, '0, '0, RESP_OK);
		// Outside the window
		add_op(1'b1, 64'h20, 64'hffff_ffff_ffff_ffff, 8'hff, RESP_ERR);
		add_op(1'b1, 64'h8000_0000_0000_0008, 64'h0, 8'hff, RESP_ERR);
		add_op(1'b0, 64'h20, '0, '0, RESP_ERR);
		add_op(1'b0, 64'h0000_0001_0000_0000, '0, '0, RESP_ERR);
		add_op(1'b0, 64'h00, '0, '0, RESP_OK);
		add_op(1'b0, 64'h08, '0, '0, RESP_OK);
		add_op(1'b0, 64'h10, '0, '0, RESP_OK);
		add_op(1'b0, 64'h18, '0, '0, RESP_OK);
	endfunction

	task automatic offer_write(input op_t op);
		random_wait();
		S_AXI_AWADDR <= op.addr;
		S_AXI_WDATA <= op.data;
		S_AXI_WSTRB <= op.strb;
		S_AXI_AWVALID <= 1'b1;
		S_AXI_WVALID <= 1'b1;
	endtask

	task automatic offer_read(input op_t op);
		random_wait();
		S_AXI_ARADDR <= op.addr;
		S_AXI_ARVALID <= 1'b1;
	endtask

	task automatic write_op(input int i);
		op_t op;
		op = ops[i];
		// A chained write is already on the bus
		if (!same_kind(i, i - 1))
			offer_write(op);
		do
			@(posedge S_AXI_ACLK);
		while (!S_AXI_AWREADY);
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WVALID <= 1'b0;
		// Next write waits on the bus while this B is pending
		if (same_kind(i, i + 1))
			offer_write(ops[i + 1]);
		random_wait();
		S_AXI_BREADY <= 1'b1;
		do
			@(posedge S_AXI_ACLK);
		while (!S_AXI_BVALID);
		S_AXI_BREADY <= 1'b0;
		check_value("S_AXI_BRESP", axil_pkg::data_t'(op.resp), axil_pkg::data_t'(S_AXI_BRESP));
		if (in_window(op.addr))
			model[op.addr[`AXIL_ADDR_LSB +: `AXIL_IDX_W]] =
				merge_bytes(model[op.addr[`AXIL_ADDR_LSB +: `AXIL_IDX_W]], op.data, op.strb);
	endtask

	task automatic read_op(input int i);
		op_t op;
		axil_pkg::data_t exp_data;
		op = ops[i];
		exp_data = in_window(op.addr) ? model[op.addr[`AXIL_ADDR_LSB +: `AXIL_IDX_W]] : '0;
		if (!same_kind(i, i - 1))
			offer_read(op);
		do
			@(posedge S_AXI_ACLK);
		while (!S_AXI_ARREADY);
		S_AXI_ARVALID <= 1'b0;
		// Next read waits on the bus while this R is pending
		if (same_kind(i, i + 1))
			offer_read(ops[i + 1]);
		do
			@(posedge S_AXI_ACLK);
		while (!S_AXI_RVALID);
		random_wait();
		S_AXI_RREADY <= 1'b1;
		@(posedge S_AXI_ACLK);
		S_AXI_RREADY <= 1'b0;
		check_value("S_AXI_RDATA", exp_data, S_AXI_RDATA);
		check_value("S_AXI_RRESP", axil_pkg::data_t'(op.resp), axil_pkg::data_t'(S_AXI_RRESP));
	endtask

	// Handshake rules, checked on every edge
	always @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
		begin
			check_rule(S_AXI_AWREADY == S_AXI_WREADY, "AWREADY and WREADY differ");
			check_rule(!(S_AXI_AWREADY && S_AXI_BVALID), "AW accepted while B is pending");
			check_rule(!(S_AXI_ARREADY && S_AXI_RVALID), "AR accepted while R is pending");
			if (prev_bvalid && !prev_bready)
				check_rule(S_AXI_BVALID, "BVALID dropped before BREADY");
			if (prev_rvalid && !prev_rready)
				check_rule(S_AXI_RVALID && (S_AXI_RDATA == prev_rdata),
					"RVALID or RDATA changed before RREADY");
		end
		prev_bvalid <= S_AXI_BVALID;
		prev_bready <= S_AXI_BREADY;
		prev_rvalid <= S_AXI_RVALID;
		prev_rready <= S_AXI_RREADY;
		prev_rdata <= S_AXI_RDATA;
	end

	initial
	begin
		wait (table_len != 0);
		repeat (RST_CYCLES + table_len * 20) @(posedge S_AXI_ACLK);
		report_failure("Timeout: the stimulus table did not finish in the allowed time");
	end

	initial
	begin
		seed = 32'h770f_c20c;
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_AWPROT = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARPROT = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		foreach (model[i])
			model[i] = '0;
		build_table();
		table_len = ops.size();
		repeat (RST_CYCLES) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		foreach (ops[i])
		begin
			if (ops[i].is_write)
				write_op(i);
			else
				read_op(i);
		end
		@(posedge S_AXI_ACLK);
		$display(">>> PASS");
		$finish;
	end

endmodule
